// ==== logic/chp_freelist_pkg.sv ====
package chp_freelist_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // freelist geometry
  ////////////////////////////////////////////////////////////////////////////

  parameter int NUM_BANKS_DFLT  = 8;                // banks in the freelist
  parameter int BANK_DEPTH_DFLT = 16;               // flids held per bank

  parameter int BANK_W = 3;                         // bank index, upper flid bits
  parameter int OFFS_W = 4;                         // offset inside a bank
  parameter int FLID_W = BANK_W + OFFS_W;

  // a flid is {bank, offset}
  typedef logic [FLID_W-1:0] chp_flid_t;

  // push payload, even parity bit on top so the xor over all bits is zero
  typedef logic [FLID_W:0] chp_flid_par_t;

  ////////////////////////////////////////////////////////////////////////////
  // pipeline and credit control
  ////////////////////////////////////////////////////////////////////////////

  parameter int POP_LAT = 3;                        // pop_v to pop_data_v in cycles

  typedef enum logic [1:0] {
    cred_init = 2'd0,                               // load the free count after reset
    cred_idle = 2'd1,                               // nothing to advertise
    cred_run  = 2'd2                                // one credit per cycle
  } chp_cred_state_t;

endpackage

// ==== logic/chp_flid_bank.sv ====
module chp_flid_bank #(
  parameter int BANK_DEPTH = 16
) (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_n,
  input  logic                          push,
  input  logic [$clog2(BANK_DEPTH)-1:0] push_offs,
  input  logic                          pop,
  output logic [$clog2(BANK_DEPTH)-1:0] pop_offs,
  output logic                          empty
);

  localparam int OW = $clog2(BANK_DEPTH);
  localparam int CW = $clog2(BANK_DEPTH + 1);

  logic [OW-1:0] stack_q [BANK_DEPTH];
  logic [CW-1:0] cnt_q;                             // number of free offsets held
  logic [OW-1:0] top_idx;
  logic          full;

  assign top_idx  = OW'(cnt_q - 1'b1);
  assign full     = (cnt_q == CW'(BANK_DEPTH));
  assign empty    = (cnt_q == '0);
  assign pop_offs = stack_q[top_idx];               // valid whenever not empty

  ////////////////////////////////////////////////////////////////////////////
  // LIFO of free offsets, starts out holding every offset of the bank
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      cnt_q <= CW'(BANK_DEPTH);
      for (int i = 0; i < BANK_DEPTH; i++) begin
        stack_q[i] <= OW'(i);
      end
    end else begin
      if (push && pop) begin
        stack_q[top_idx] <= push_offs;              // replace top, depth unchanged
      end else if (push && !full) begin
        stack_q[cnt_q[OW-1:0]] <= push_offs;
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !empty) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // the freelist only pops banks it saw non-empty, and a flid is never
  // returned to a bank that already holds all of its offsets
  a_bank_no_over_under: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    !(push && !pop && full) && !(pop && empty)
  ) else $error("flid bank pushed while full or popped while empty");

endmodule

// ==== logic/chp_freelist.sv ====
module chp_freelist #(
  parameter int NUM_BANKS  = chp_freelist_pkg::NUM_BANKS_DFLT,
  parameter int BANK_DEPTH = chp_freelist_pkg::BANK_DEPTH_DFLT
) (
  input  logic                            hqm_gated_clk,
  input  logic                            hqm_gated_rst_n,
  input  logic                            pop_v,
  input  logic                            push_v,
  input  chp_freelist_pkg::chp_flid_par_t push_data,
  output logic                            pop_data_v,
  output chp_freelist_pkg::chp_flid_t     pop_data,
  output logic                            err_pop_empty,
  output logic                            err_push_parity,
  output logic                            free_inc,
  output logic                            free_dec,
  output logic                            push_ok,
  output chp_freelist_pkg::chp_flid_t     push_flid
);

  import chp_freelist_pkg::*;

  localparam int BW = $clog2(NUM_BANKS);
  localparam int OW = $clog2(BANK_DEPTH);

  logic                 parity_ok;
  logic [BW-1:0]        push_bank;
  logic [OW-1:0]        push_offs;
  logic [NUM_BANKS-1:0] bank_push;
  logic [NUM_BANKS-1:0] bank_pop;
  logic [NUM_BANKS-1:0] bank_empty;
  logic [OW-1:0]        bank_pop_offs [NUM_BANKS];

  logic                 p0_v_q;                     // request registered in stage 0
  logic                 p1_v_q;                     // stage 1 took a flid
  chp_flid_t            p1_flid_q;
  logic [BW-1:0]        rr_last_q;                  // bank used by the last pop
  logic [BW-1:0]        rr_cand;
  logic [BW-1:0]        sel_bank;
  logic                 sel_found;

  ////////////////////////////////////////////////////////////////////////////
  // push side
  ////////////////////////////////////////////////////////////////////////////

  assign parity_ok = ~^push_data;                   // even parity over flid and bit
  assign push_flid = push_data[FLID_W-1:0];
  assign push_ok   = push_v && parity_ok;
  assign free_inc  = push_ok;
  assign push_bank = push_flid[OW +: BW];
  assign push_offs = push_flid[OW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 picks banks round robin starting after the last bank used
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_found = 1'b0;
    sel_bank  = rr_last_q;
    rr_cand   = rr_last_q;
    for (int i = 1; i <= NUM_BANKS; i++) begin
      rr_cand = rr_last_q + BW'(i);                 // wraps through all banks
      if (!sel_found && !bank_empty[rr_cand]) begin
        sel_found = 1'b1;
        sel_bank  = rr_cand;
      end
    end
  end

  assign free_dec = p0_v_q && sel_found;            // pop accepted this cycle

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign bank_push[b] = push_ok && (push_bank == BW'(b));
    assign bank_pop[b]  = free_dec && (sel_bank == BW'(b));

    chp_flid_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) i_chp_flid_bank (
      .hqm_gated_clk   (hqm_gated_clk),
      .hqm_gated_rst_n (hqm_gated_rst_n),
      .push            (bank_push[b]),
      .push_offs       (push_offs),
      .pop             (bank_pop[b]),
      .pop_offs        (bank_pop_offs[b]),
      .empty           (bank_empty[b])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // pop pipeline and error flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      p0_v_q          <= 1'b0;
      p1_v_q          <= 1'b0;
      rr_last_q       <= '0;
      pop_data_v      <= 1'b0;
      pop_data        <= '0;
      err_pop_empty   <= 1'b0;
      err_push_parity <= 1'b0;
    end else begin
      p0_v_q          <= pop_v;
      p1_v_q          <= free_dec;
      pop_data_v      <= p1_v_q;
      err_pop_empty   <= p0_v_q && !sel_found;      // no bank had a free flid
      err_push_parity <= push_v && !parity_ok;      // bad push is dropped
      if (free_dec) begin
        rr_last_q <= sel_bank;
      end
      if (p1_v_q) begin
        pop_data <= p1_flid_q;
      end
    end
  end

  always_ff @(posedge hqm_gated_clk) begin
    if (free_dec) begin
      p1_flid_q <= chp_flid_t'({sel_bank, bank_pop_offs[sel_bank]});
    end
  end

  // the request that flagged empty must not also return a flid
  a_pop_err_no_data: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    err_pop_empty |=> !pop_data_v
  ) else $error("pop request both flagged empty and returned a flid");

  a_no_pop_empty: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    !err_pop_empty
  ) else $error("pop requested with no free flid, requester ignored credits");

endmodule

// ==== logic/chp_freelist_credit.sv ====
module chp_freelist_credit #(
  parameter int NUM_FLIDS = chp_freelist_pkg::NUM_BANKS_DFLT *
                            chp_freelist_pkg::BANK_DEPTH_DFLT
) (
  input  logic hqm_gated_clk,
  input  logic hqm_gated_rst_n,
  input  logic free_inc,
  input  logic free_dec,
  output logic credit
);

  import chp_freelist_pkg::*;

  localparam int CW = $clog2(NUM_FLIDS + 1);

  chp_cred_state_t state_q;
  logic [CW-1:0]   cnt_q;                           // free flids not yet advertised
  logic [CW-1:0]   held_q;                          // credits the requester still holds

  ////////////////////////////////////////////////////////////////////////////
  // credit FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      state_q <= cred_init;
      cnt_q   <= '0;
      held_q  <= '0;
      credit  <= 1'b0;
    end else begin
      held_q <= held_q + CW'(credit) - CW'(free_dec);
      case (state_q)
        cred_init: begin
          cnt_q   <= CW'(NUM_FLIDS) + CW'(free_inc);
          credit  <= 1'b0;
          state_q <= cred_run;
        end
        cred_run: begin
          if (cnt_q != '0) begin
            credit <= 1'b1;
            cnt_q  <= cnt_q - 1'b1 + CW'(free_inc);
          end else begin
            credit <= 1'b0;
            if (free_inc) begin
              cnt_q <= cnt_q + 1'b1;                // stay, credit goes out next cycle
            end else begin
              state_q <= cred_idle;
            end
          end
        end
        cred_idle: begin
          credit <= 1'b0;
          if (free_inc) begin
            cnt_q   <= cnt_q + 1'b1;
            state_q <= cred_run;
          end
        end
        default: begin
          credit  <= 1'b0;
          state_q <= cred_init;
        end
      endcase
    end
  end

  // every accepted pop must be backed by a credit handed out earlier
  a_pop_within_credit: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    free_dec |-> (held_q != '0)
  ) else $error("accepted pops exceed the credits issued");

endmodule

// ==== logic/chp_freelist_checker.sv ====
module chp_freelist_checker #(
  parameter int NUM_BANKS  = chp_freelist_pkg::NUM_BANKS_DFLT,
  parameter int BANK_DEPTH = chp_freelist_pkg::BANK_DEPTH_DFLT
) (
  input  logic                        hqm_gated_clk,
  input  logic                        hqm_gated_rst_n,
  input  logic                        pop_data_v,
  input  chp_freelist_pkg::chp_flid_t pop_data,
  input  logic                        push_ok,
  input  chp_freelist_pkg::chp_flid_t push_flid,
  output logic                        err_push_inactive
);

  localparam int NUM_FLIDS = NUM_BANKS * BANK_DEPTH;

  logic [NUM_FLIDS-1:0] active_q;                   // handed out, not yet returned
  logic [NUM_FLIDS-1:0] active_nxt;
  logic                 inactive_push;

  ////////////////////////////////////////////////////////////////////////////
  // active flid tracking
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    active_nxt = active_q;
    if (pop_data_v) begin
      active_nxt[pop_data] = 1'b1;
    end
    if (push_ok) begin
      active_nxt[push_flid] = 1'b0;
    end
    // a good push of a flid nobody holds is a double free
    inactive_push = push_ok && !active_q[push_flid];
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      active_q          <= '0;
      err_push_inactive <= 1'b0;
    end else begin
      active_q          <= active_nxt;
      err_push_inactive <= inactive_push;
    end
  end

  a_no_push_inactive: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    !err_push_inactive
  ) else $error("flid pushed back while not active, double free");

  // the freelist must never hand out a flid that is still held
  a_pop_not_active: assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_n)
    pop_data_v |-> !active_q[pop_data]
  ) else $error("flid popped twice without being returned");

endmodule

// ==== logic/chp_freelist_top.sv ====
module chp_freelist_top #(
  parameter int NUM_BANKS  = chp_freelist_pkg::NUM_BANKS_DFLT,
  parameter int BANK_DEPTH = chp_freelist_pkg::BANK_DEPTH_DFLT
) (
  input  logic                            hqm_gated_clk,
  input  logic                            hqm_gated_rst_n,
  output logic                            credit,
  input  logic                            pop_v,
  output logic                            pop_data_v,
  output chp_freelist_pkg::chp_flid_t     pop_data,
  input  logic                            push_v,
  input  chp_freelist_pkg::chp_flid_par_t push_data,
  output logic                            err_pop_empty,
  output logic                            err_push_parity,
  output logic                            err_push_inactive
);

  import chp_freelist_pkg::*;

  logic      free_inc;
  logic      free_dec;
  logic      push_ok;
  chp_flid_t push_flid;

  chp_freelist #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) i_chp_freelist (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_n (hqm_gated_rst_n),
    .pop_v           (pop_v),
    .push_v          (push_v),
    .push_data       (push_data),
    .pop_data_v      (pop_data_v),
    .pop_data        (pop_data),
    .err_pop_empty   (err_pop_empty),
    .err_push_parity (err_push_parity),
    .free_inc        (free_inc),
    .free_dec        (free_dec),
    .push_ok         (push_ok),
    .push_flid       (push_flid)
  );

  chp_freelist_credit #(
    .NUM_FLIDS (NUM_BANKS * BANK_DEPTH)
  ) i_chp_freelist_credit (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_n (hqm_gated_rst_n),
    .free_inc        (free_inc),
    .free_dec        (free_dec),
    .credit          (credit)
  );

  chp_freelist_checker #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) i_chp_freelist_checker (
    .hqm_gated_clk     (hqm_gated_clk),
    .hqm_gated_rst_n   (hqm_gated_rst_n),
    .pop_data_v        (pop_data_v),
    .pop_data          (pop_data),
    .push_ok           (push_ok),
    .push_flid         (push_flid),
    .err_push_inactive (err_push_inactive)
  );

endmodule

// ==== sim/chp_freelist_tests.svh ====
`ifndef CHP_FREELIST_TESTS_SVH
`define CHP_FREELIST_TESTS_SVH

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_credits();
    check_val("credit", 32'(credit), 32'd0);
    check_val("pop_data_v", 32'(pop_data_v), 32'd0);
    check_val("pop_data", 32'(pop_data), 32'd0);
    check_val("err_pop_empty", 32'(err_pop_empty), 32'd0);
    check_val("err_push_parity", 32'(err_push_parity), 32'd0);
    check_val("err_push_inactive", 32'(err_push_inactive), 32'd0);
    next_cycle();
    check_val("credit", 32'(credit), 32'd0);        // first credit is one cycle later
    wait_credit_total(NUM_FLIDS, NUM_FLIDS + 10);
    repeat (10) next_cycle();
    check_val("credit_total", 32'(cred_total), 32'(NUM_FLIDS));
  endtask

  task automatic test_drain_all();
    check_val("credits_held", 32'(cred_held), 32'(NUM_FLIDS));
    ret_q.delete();
    for (int i = 0; i < NUM_FLIDS; i++) begin
      next_cycle();
      issue_pop();
    end
    wait_pops_drained(2 * POP_LAT + 4);
    check_val("pop_data_count", 32'(ret_q.size()), 32'(NUM_FLIDS));
  endtask

  task automatic test_return_and_repop();
    chp_flid_t picked[$];
    chp_flid_t f;
    bit        chosen [NUM_FLIDS];
    int        base;
    int        tries;
    base  = cred_total;
    tries = 0;
    while (picked.size() < 12) begin
      if (tries >= 1000) begin
        stop_on_fail("random choice found too few active flids to return");
      end
      f = chp_flid_t'((lcg_next() >> 16) % NUM_FLIDS);
      tries++;
      if (active_m[f] && !chosen[f]) begin
        chosen[f] = 1'b1;
        picked.push_back(f);
      end
    end
    foreach (picked[i]) begin
      next_cycle();
      issue_push(picked[i], 1'b0);
    end
    wait_credit_total(base + picked.size(), 40);
    repeat (5) next_cycle();
    check_val("credit_total", 32'(cred_total), 32'(base + picked.size()));
    ret_q.delete();
    foreach (picked[i]) begin
      next_cycle();
      issue_pop();
    end
    wait_pops_drained(2 * POP_LAT + 4);
    check_val("pop_data_count", 32'(ret_q.size()), 32'(picked.size()));
    foreach (ret_q[i]) begin
      check_val("pop_data_in_returned_set", 32'(chosen[ret_q[i]]), 32'd1);
    end
  endtask

  task automatic test_bad_parity();
    int base;
    held_flid = ret_q[0];                           // active since the last test
    base      = cred_total;
    next_cycle();
    issue_push(held_flid, 1'b1);
    exp_parity_at = cycle + 1;
    repeat (8) next_cycle();
    check_val("credit_total", 32'(cred_total), 32'(base));
  endtask

  task automatic test_pop_when_empty();
    check_val("credits_held", 32'(cred_held), 32'd0);
    $assertoff;
    next_cycle();
    pop_v        = 1'b1;                            // deliberately without a credit
    exp_empty_at = cycle + 2;
    repeat (6) next_cycle();
    $asserton;
  endtask

  task automatic test_double_free();
    int base;
    base = cred_total;
    // still active after the dropped push, so this return is legal
    next_cycle();
    issue_push(held_flid, 1'b0);
    next_cycle();
    $assertoff;
    issue_push(held_flid, 1'b0);
    exp_inactive_at = cycle + 1;
    repeat (3) next_cycle();
    $asserton;
    wait_credit_total(base + 2, 20);
    repeat (4) next_cycle();
    check_val("credit_total", 32'(cred_total), 32'(base + 2));
  endtask

`endif

// ==== sim/chp_freelist_tb.sv ====
module chp_freelist_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import chp_freelist_pkg::*;

  localparam int NUM_FLIDS = NUM_BANKS_DFLT * BANK_DEPTH_DFLT;

  logic          hqm_gated_clk;
  logic          hqm_gated_rst_n;
  logic          credit;
  logic          pop_v;
  logic          pop_data_v;
  chp_flid_t     pop_data;
  logic          push_v;
  chp_flid_par_t push_data;
  logic          err_pop_empty;
  logic          err_push_parity;
  logic          err_push_inactive;

  ////////////////////////////////////////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////////////////////////////////////////

  int          cycle;
  int          cred_total;                          // credit pulses seen since reset
  int          cred_held;                           // credits not yet spent on a pop
  int          pop_due[$];                          // cycle in which each pop must return
  chp_flid_t   ret_q[$];                            // flids returned by the DUT
  bit          active_m [NUM_FLIDS];
  int          exp_empty_at;
  int          exp_parity_at;
  int          exp_inactive_at;
  chp_flid_t   held_flid;                           // flid carried from the parity test
  logic [31:0] lcg_state;

  always #10 hqm_gated_clk = ~hqm_gated_clk;

  chp_freelist_top #(
    .NUM_BANKS  (NUM_BANKS_DFLT),
    .BANK_DEPTH (BANK_DEPTH_DFLT)
  ) chp_freelist_top_inst (
    .hqm_gated_clk     (hqm_gated_clk),
    .hqm_gated_rst_n   (hqm_gated_rst_n),
    .credit            (credit),
    .pop_v             (pop_v),
    .pop_data_v        (pop_data_v),
    .pop_data          (pop_data),
    .push_v            (push_v),
    .push_data         (push_data),
    .err_pop_empty     (err_pop_empty),
    .err_push_parity   (err_push_parity),
    .err_push_inactive (err_push_inactive)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_fail(string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_val(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      stop_on_fail($sformatf("ERR %0t %s actual %0h expected %0h", $time, name,
                             actual, expected));
    end
  endtask

  // one clock cycle, outputs are sampled 2 ns after the edge and inputs drop
  task automatic next_cycle();
    logic exp_data_v;
    @(posedge hqm_gated_clk);
    #2;
    cycle++;
    if (credit) begin
      cred_total++;
      cred_held++;
    end
    exp_data_v = (pop_due.size() > 0) && (pop_due[0] == cycle);
    check_val("pop_data_v", 32'(pop_data_v), 32'(exp_data_v));
    if (pop_data_v) begin
      void'(pop_due.pop_front());
      check_val("pop_data_already_active", 32'(active_m[pop_data]), 32'd0);
      active_m[pop_data] = 1'b1;
      ret_q.push_back(pop_data);
    end
    check_val("err_pop_empty", 32'(err_pop_empty), 32'(cycle == exp_empty_at));
    check_val("err_push_parity", 32'(err_push_parity), 32'(cycle == exp_parity_at));
    check_val("err_push_inactive", 32'(err_push_inactive), 32'(cycle == exp_inactive_at));
    pop_v  = 1'b0;
    push_v = 1'b0;
  endtask

  task automatic issue_pop();
    if (cred_held == 0) begin
      stop_on_fail("pop attempted while the requester holds no credit");
    end
    pop_v = 1'b1;
    pop_due.push_back(cycle + POP_LAT);
    cred_held--;
  endtask

  task automatic issue_push(chp_flid_t flid, bit bad_par);
    push_v    = 1'b1;
    push_data = {(^flid) ^ bad_par, flid};          // even parity unless flipped
    if (!bad_par) begin
      active_m[flid] = 1'b0;
    end
  endtask

  task automatic wait_credit_total(int target, int limit);
    int n;
    n = 0;
    while (cred_total < target) begin
      if (n >= limit) begin
        stop_on_fail($sformatf("timeout waiting for %0d credits, only %0d arrived",
                               target, cred_total));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_pops_drained(int limit);
    int n;
    n = 0;
    while (pop_due.size() > 0) begin
      if (n >= limit) begin
        stop_on_fail("timeout waiting for outstanding pops to return a flid");
      end
      next_cycle();
      n++;
    end
  endtask

`include "chp_freelist_tests.svh"

  initial begin
    hqm_gated_clk   = 1'b0;
    hqm_gated_rst_n = 1'b0;
    pop_v           = 1'b0;
    push_v          = 1'b0;
    push_data       = '0;
    cycle           = 0;
    cred_total      = 0;
    cred_held       = 0;
    exp_empty_at    = -1;
    exp_parity_at   = -1;
    exp_inactive_at = -1;
    held_flid       = '0;
    lcg_state       = 32'hb84a;
    repeat (16) next_cycle();
    hqm_gated_rst_n = 1'b1;
    test_reset_credits();
    test_drain_all();
    test_return_and_repop();
    test_bad_parity();
    test_pop_when_empty();                          // must run while the freelist is empty
    test_double_free();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+sim
logic/chp_freelist_pkg.sv
logic/chp_flid_bank.sv
logic/chp_freelist.sv
logic/chp_freelist_credit.sv
logic/chp_freelist_checker.sv
logic/chp_freelist_top.sv
sim/chp_freelist_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the freelist testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f filelist.f --top-module chp_freelist_tb -Mdir obj_dir -o chp_freelist_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/chp_freelist_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q 'Test failures found' "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q 'All tests passed!' "$LOG"; then
  echo "simulation did not complete"
  exit 1
fi
echo "simulation PASSED"
exit 0
